// File: dv/alu_tests.txt
# columns: name a b target imm opcode result status naddr, all values hex
# error access: name err offset direction (w or r), outcome must stay as before
add_basic 00000005 00000003 00000000 00000000 0 00000008 0 00000000
add_wrap ffffffff 00000002 00000000 00000000 0 00000001 0 00000000
sub_basic 0000000a 00000003 00000000 00000000 1 00000007 0 00000000
sub_wrap 00000001 00000002 00000000 00000000 1 ffffffff 0 00000000
shl_fill 0000000f 00000004 00000000 00000000 2 000000ff 0 00000000
shr_fill f0000000 00000008 00000000 00000000 3 fff00000 0 00000000
shl_sat 12345678 00000020 00000000 00000000 2 ffffffff 0 00000000
shr_big 00000000 00000100 00000000 00000000 3 ffffffff 0 00000000
ldi_high 12345678 00000000 00000000 0001abcd 5 abcd5678 0 00000000
ldi_low 12345678 00000000 00000000 0000beef 6 1234beef 0 00000000
mov cafef00d 00000000 00000000 00000000 4 cafef00d 0 00000000
mov2 0badbeef 00000000 00000000 00000000 7 0badbeef 0 00000000
eq_true 00000042 00000042 00000000 00000000 8 0badbeef 1 00000000
ltu_false 80000000 00000001 00000000 00000000 9 0badbeef 0 00000000
gtu_true 80000000 00000001 00000000 00000000 a 0badbeef 1 00000000
notf1 00000000 00000000 00000000 00020000 b 0badbeef 0 00000000
andf 00000000 00000000 00000000 00060000 c 0badbeef 1 00000000
cpyf1 00000000 00000000 00000000 00000000 d 0badbeef 0 00000000
jmp 00000000 00000000 00001000 00000000 e 0badbeef 2 00001000
err_wr_result err 14 w
err_rd_unmapped err 20 r
eq_true2 00000007 00000007 00000000 00000000 8 0badbeef 1 00000000
jmpf_taken 00000000 00000000 00002000 00000000 f 0badbeef 3 00002000
add_clears 00000001 00000001 00000000 00000000 0 00000002 1 00000000
ltu_false2 00000005 00000003 00000000 00000000 9 00000002 0 00000000
jmpf_not 00000000 00000000 00003000 00000000 f 00000002 0 00000000

// File: filelist.f
logic/alu_pkg.sv
logic/ripple_adder.sv
logic/ones_shifter.sv
logic/half_loader.sv
logic/alu_core.sv
logic/alu_axil_regs.sv
logic/alu_top.sv
dv/alu_tb_clock.sv
dv/alu_checker.sv
dv/alu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb \
    -Mdir obj_dir -o alu_sim -f filelist.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/alu_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// File: dv/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb
    import alu_pkg::*;
();

    logic             clock;
    logic             rst;
    axil_req_t        axil_req;
    axil_rsp_t        axil_rsp;
    int               errors;
    logic             hung;
    int               seed;
    int               fd;
    int               n;
    int               count;
    int               timeout_cycles = 100;
    logic [8*128-1:0] line;
    logic [8*32-1:0]  name;
    logic [8*32-1:0]  kind;
    logic [8*32-1:0]  dir;
    word_t            a;
    word_t            b;
    word_t            target;
    word_t            imm;
    word_t            opcode;
    word_t            exp_result;
    word_t            exp_status;
    word_t            exp_naddr;
    word_t            offset;
    word_t            last_result;
    word_t            last_status;
    word_t            last_naddr;

    alu_tb_clock alu_tb_clock_inst (
        .clock (clock),
        .rst   (rst)
    );

    alu_top alu_top_inst (
        .clock    (clock),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    // stops all further traffic, the run ends at the closing summary.
    task automatic flag_failure(input string what);
        errors++;
        hung = 1'b1;
        $display("%0s", what);
    endtask

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (!hung)
        begin
            assert (actual === expected)
            else
            begin
                $display("mismatch %0s %0s: expected %h, actual %h", name, what, expected,
                         actual);
                errors++;
            end
        end
    endtask

    // roughly one response in four is held off for 0 to 3 cycles.
    task automatic stall_ready();
        int cycles;
        cycles = 0;
        if (($random(seed) & 3) == 0)
        begin
            cycles = $random(seed) & 3;
        end
        repeat (cycles) @(posedge clock);
    endtask

    task automatic write_reg(input word_t addr, input word_t data, output logic [1:0] resp);
        int waited;
        resp = RESP_OKAY;
        if (hung)
        begin
            return;
        end
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wvalid  = 1'b1;
        waited = 0;
        @(negedge clock);
        while (!(axil_rsp.awready && axil_rsp.wready) && waited < timeout_cycles)
        begin
            @(negedge clock);
            waited++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready))
        begin
            flag_failure("timeout waiting for the write address and data handshake");
            return;
        end
        @(posedge clock);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        waited = 0;
        @(negedge clock);
        while (!axil_rsp.bvalid && waited < timeout_cycles)
        begin
            @(negedge clock);
            waited++;
        end
        if (!axil_rsp.bvalid)
        begin
            flag_failure("timeout waiting for the write response");
            return;
        end
        resp = axil_rsp.bresp;
        stall_ready();
        @(posedge clock);
        #1;
        axil_req.bready = 1'b1;
        @(posedge clock); // response taken here.
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic read_reg(input word_t addr, output word_t data, output logic [1:0] resp);
        int waited;
        data = '0;
        resp = RESP_OKAY;
        if (hung)
        begin
            return;
        end
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        waited = 0;
        @(negedge clock);
        while (!axil_rsp.arready && waited < timeout_cycles)
        begin
            @(negedge clock);
            waited++;
        end
        if (!axil_rsp.arready)
        begin
            flag_failure("timeout waiting for the read address handshake");
            return;
        end
        @(posedge clock);
        #1;
        axil_req.arvalid = 1'b0;
        waited = 0;
        @(negedge clock);
        while (!axil_rsp.rvalid && waited < timeout_cycles)
        begin
            @(negedge clock);
            waited++;
        end
        if (!axil_rsp.rvalid)
        begin
            flag_failure("timeout waiting for the read data");
            return;
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        stall_ready();
        @(posedge clock);
        #1;
        axil_req.rready = 1'b1;
        @(posedge clock);
        #1;
        axil_req.rready = 1'b0;
    endtask

    task automatic write_checked(input word_t addr, input word_t data);
        logic [1:0] resp;
        write_reg(addr, data, resp);
        check_value("bresp", word_t'(RESP_OKAY), word_t'(resp));
    endtask

    task automatic read_checked(input word_t addr, input string what, input word_t expected);
        word_t      data;
        logic [1:0] resp;
        read_reg(addr, data, resp);
        check_value({what, " rresp"}, word_t'(RESP_OKAY), word_t'(resp));
        check_value(what, expected, data);
    endtask

    task automatic check_outcome(input word_t result, input word_t status, input word_t naddr);
        read_checked(word_t'(REG_RESULT), "result", result);
        read_checked(word_t'(REG_STATUS), "status", status);
        read_checked(word_t'(REG_NADDR), "naddr", naddr);
    endtask

    task automatic run_operation();
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, a, b, target, imm, opcode,
                    exp_result, exp_status, exp_naddr);
        if (n != 9)
        begin
            flag_failure("malformed operation line in the test file");
            return;
        end
        write_checked(word_t'(REG_OPA), a);
        write_checked(word_t'(REG_OPB), b);
        write_checked(word_t'(REG_TARGET), target);
        write_checked(word_t'(REG_IMM), imm);
        write_checked(word_t'(REG_CTRL), opcode); // starts the operation.
        check_outcome(exp_result, exp_status, exp_naddr);
        last_result = exp_result;
        last_status = exp_status;
        last_naddr  = exp_naddr;
    endtask

    task automatic run_error_access();
        word_t      data;
        logic [1:0] resp;
        n = $sscanf(line, "%s %s %h %s", name, kind, offset, dir);
        if (n != 4)
        begin
            flag_failure("malformed error access line in the test file");
            return;
        end
        if (dir == 256'("w"))
        begin
            write_reg(offset, 32'hffff_ffff, resp);
            check_value("bresp", word_t'(RESP_SLVERR), word_t'(resp));
        end
        else
        begin
            read_reg(offset, data, resp);
            check_value("rresp", word_t'(RESP_SLVERR), word_t'(resp));
            check_value("rdata", '0, data);
        end
        check_outcome(last_result, last_status, last_naddr); // outcome untouched.
    endtask

    initial
    begin
        seed        = 32'h411b9830;
        errors      = 0;
        hung        = 1'b0;
        axil_req    = '0;
        last_result = '0;
        last_status = '0;
        last_naddr  = '0;
        fd = $fopen("dv/alu_tests.txt", "r");
        if (fd == 0)
        begin
            flag_failure("cannot open dv/alu_tests.txt");
        end
        count = 0;
        @(posedge clock);
        while (rst && count < timeout_cycles)
        begin
            @(posedge clock);
            count++;
        end
        if (rst)
        begin
            flag_failure("reset was never released");
        end
        @(posedge clock);
        #1;
        while (!hung && !$feof(fd))
        begin
            line = '0;
            name = '0;
            kind = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %s", name, kind);
            if (n >= 2 && name != 256'("#"))
            begin
                if (kind == 256'("err"))
                begin
                    run_error_access();
                end
                else
                begin
                    run_operation();
                end
            end
        end
        if (fd != 0)
        begin
            $fclose(fd);
        end
        $display("errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/alu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module alu_axil_checker
    import alu_pkg::*;
(
    input logic      clock,
    input logic      rst,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp,
    input alu_req_t  req
);

    bvalid_held: assert property (@(posedge clock) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge clock) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    rdata_stable: assert property (@(posedge clock) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rdata))
        else $error("rdata changed while the read response was stalled");

    start_single: assert property (@(posedge clock) disable iff (rst)
        req.start |=> !req.start)
        else $error("start high for two cycles in a row");

endmodule

bind alu_axil_regs alu_axil_checker alu_axil_checker_inst (
    .clock    (clock),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .req      (req)
);

`default_nettype wire

// File: dv/alu_tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb_clock
(
    output logic clock,
    output logic rst
);

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock; // 8 ns period.
    end

    initial
    begin
        rst = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: logic/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top
    import alu_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);

    alu_req_t req;
    alu_res_t res;

    alu_axil_regs alu_axil_regs_inst (
        .clock    (clock),
        .rst      (rst),
        .axil_req (axil_req),
        .res      (res),
        .axil_rsp (axil_rsp),
        .req      (req)
    );

    alu_core alu_core_inst (
        .clock (clock),
        .rst   (rst),
        .req   (req),
        .res   (res)
    );

endmodule

`default_nettype wire

// File: logic/alu_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module alu_axil_regs
    import alu_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  axil_req_t axil_req,
    input  alu_res_t  res,
    output axil_rsp_t axil_rsp,
    output alu_req_t  req
);

    word_t      opa;
    word_t      opb;
    word_t      target;
    word_t      imm;
    word_t      status;
    word_t      rd_word;
    reg_addr_t  wr_off;
    reg_addr_t  rd_off;
    logic       wr_in_map;
    logic       rd_in_map;
    logic       wr_ok;
    logic       rd_ok;
    logic       wr_accept;
    logic       rd_accept;
    logic       bvalid;
    logic [1:0] bresp;
    logic       rvalid;
    logic [1:0] rresp;
    word_t      rdata;

    assign wr_off    = axil_req.awaddr[REG_ADDR_W-1:0];
    assign rd_off    = axil_req.araddr[REG_ADDR_W-1:0];
    assign wr_in_map = (axil_req.awaddr[WORD_W-1:REG_ADDR_W] == '0);
    assign rd_in_map = (axil_req.araddr[WORD_W-1:REG_ADDR_W] == '0);

    assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid; // aw and w together.
    assign rd_accept = axil_req.arvalid & ~rvalid;

    always_comb
    begin
        case (wr_off)
            REG_OPA, REG_OPB, REG_TARGET, REG_IMM, REG_CTRL: wr_ok = wr_in_map;
            default:                                         wr_ok = 1'b0;
        endcase
    end

    always_comb
    begin
        status                  = '0;
        status[STAT_FLAG_BIT]   = res.flag;
        status[STAT_ADDRCH_BIT] = res.addrch;
    end

    always_comb
    begin
        rd_ok   = rd_in_map;
        rd_word = '0;
        case (rd_off)
            REG_OPA:    rd_word = opa;
            REG_OPB:    rd_word = opb;
            REG_TARGET: rd_word = target;
            REG_IMM:    rd_word = imm;
            REG_CTRL:   rd_word = '0; // write only.
            REG_RESULT: rd_word = res.result;
            REG_STATUS: rd_word = status;
            REG_NADDR:  rd_word = res.naddr;
            default:    rd_ok = 1'b0;
        endcase
        if (!rd_ok)
        begin
            rd_word = '0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            opa    <= '0;
            opb    <= '0;
            target <= '0;
            imm    <= '0;
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
            rdata  <= '0;
        end
        else
        begin
            if (wr_accept)
            begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                if (wr_in_map)
                begin
                    case (wr_off)
                        REG_OPA:    opa    <= axil_req.wdata;
                        REG_OPB:    opb    <= axil_req.wdata;
                        REG_TARGET: target <= axil_req.wdata;
                        REG_IMM:    imm    <= axil_req.wdata;
                        default:    ;
                    endcase
                end
            end
            else if (bvalid && axil_req.bready)
            begin
                bvalid <= 1'b0;
            end

            if (rd_accept)
            begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end
            else if (rvalid && axil_req.rready)
            begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb
    begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bresp   = bresp;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = ~rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
        axil_rsp.rvalid  = rvalid;
    end

    always_comb
    begin
        req.start   = wr_accept & wr_in_map & (wr_off == REG_CTRL); // one cycle pulse.
        req.op      = alu_op_e'(axil_req.wdata[3:0]);
        req.a       = opa;
        req.b       = opb;
        req.target  = target;
        req.value   = imm[HALF_W-1:0];
        req.highlow = imm[IMM_HIGHLOW_BIT];
        req.f1      = imm[IMM_F1_BIT];
        req.f2      = imm[IMM_F2_BIT];
    end

endmodule

`default_nettype wire

// File: logic/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core
    import alu_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  alu_req_t req,
    output alu_res_t res
);

    logic  sub_sel;
    logic  shift_left;
    word_t add_b;
    word_t sum;
    word_t shifted;
    word_t loaded;
    word_t result_next;
    logic  flag_next;

    assign sub_sel    = (req.op == OP_SUB);
    assign add_b      = sub_sel ? ~req.b : req.b; // a + ~b + 1.
    assign shift_left = (req.op == OP_SHL);

    ripple_adder ripple_adder_inst (
        .a        (req.a),
        .b        (add_b),
        .carry_in (sub_sel),
        .sum      (sum)
    );

    ones_shifter ones_shifter_inst (
        .data    (req.a),
        .amount  (req.b),
        .left    (shift_left),
        .shifted (shifted)
    );

    half_loader half_loader_inst (
        .base    (req.a),
        .value   (req.value),
        .highlow (req.highlow),
        .loaded  (loaded)
    );

    always_comb
    begin
        case (req.op)
            OP_ADD, OP_SUB:     result_next = sum;
            OP_SHL, OP_SHR:     result_next = shifted;
            OP_LDI_A, OP_LDI_B: result_next = loaded;
            default:            result_next = req.a; // both moves.
        endcase
    end

    always_comb
    begin
        case (req.op)
            OP_EQ:    flag_next = (req.a == req.b);
            OP_LTU:   flag_next = (req.a < req.b);
            OP_GTU:   flag_next = (req.a > req.b);
            OP_NOTF1: flag_next = ~req.f1;
            OP_ANDF:  flag_next = req.f1 & req.f2;
            default:  flag_next = req.f1;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            res <= '0;
        end
        else if (req.start)
        begin
            case (req.op)
                OP_ADD, OP_SUB, OP_SHL, OP_SHR, OP_MOV, OP_LDI_A, OP_LDI_B, OP_MOV2:
                begin
                    res.result <= result_next;
                    res.addrch <= 1'b0;
                    res.naddr  <= '0;
                end
                OP_EQ, OP_LTU, OP_GTU, OP_NOTF1, OP_ANDF, OP_CPYF1:
                begin
                    res.flag   <= flag_next;
                    res.addrch <= 1'b0;
                    res.naddr  <= '0;
                end
                OP_JMP:
                begin
                    res.addrch <= 1'b1;
                    res.naddr  <= req.target;
                end
                default:
                begin
                    // branch on the flag of the last compare.
                    res.addrch <= res.flag;
                    res.naddr  <= res.flag ? req.target : '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/half_loader.sv
`timescale 1ns/1ps
`default_nettype none

module half_loader
    import alu_pkg::*;
(
    input  word_t base,
    input  half_t value,
    input  logic  highlow,
    output word_t loaded
);

    always_comb
    begin
        if (highlow)
        begin
            loaded = {value, base[HALF_W-1:0]}; // upper half replaced.
        end
        else
        begin
            loaded = {base[WORD_W-1:HALF_W], value};
        end
    end

endmodule

`default_nettype wire

// File: logic/ones_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module ones_shifter
    import alu_pkg::*;
(
    input  word_t data,
    input  word_t amount,
    input  logic  left,
    output word_t shifted
);

    shamt_t amt;
    word_t  inverted;
    word_t  moved;

    // anything at or above the word width clears the inverted word.
    always_comb
    begin
        if (amount >= word_t'(WORD_W))
        begin
            amt = shamt_t'(WORD_W);
        end
        else
        begin
            amt = amount[SHAMT_W-1:0];
        end
    end

    assign inverted = ~data;
    assign moved    = left ? (inverted << amt) : (inverted >> amt);
    assign shifted  = ~moved; // zeros shifted in come back as ones.

endmodule

`default_nettype wire

// File: logic/ripple_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ripple_adder
    import alu_pkg::*;
(
    input  word_t a,
    input  word_t b,
    input  logic  carry_in,
    output word_t sum
);

    word_t carry; // carry into each bit.

    assign carry[0] = carry_in;

    for (genvar i = 0; i < WORD_W; i++)
    begin : g_bit
        assign sum[i] = a[i] ^ b[i] ^ carry[i];
        if (i < WORD_W - 1)
        begin : g_carry
            assign carry[i+1] = (a[i] & b[i]) | (a[i] & carry[i]) | (b[i] & carry[i]);
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int WORD_W     = 32;
    localparam int HALF_W     = 16;
    localparam int SHAMT_W    = 6;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [HALF_W-1:0]     half_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_SHL   = 4'd2,
        OP_SHR   = 4'd3,
        OP_MOV   = 4'd4,
        OP_LDI_A = 4'd5,
        OP_LDI_B = 4'd6,
        OP_MOV2  = 4'd7,
        OP_EQ    = 4'd8,
        OP_LTU   = 4'd9,
        OP_GTU   = 4'd10,
        OP_NOTF1 = 4'd11,
        OP_ANDF  = 4'd12,
        OP_CPYF1 = 4'd13,
        OP_JMP   = 4'd14,
        OP_JMPF  = 4'd15
    } alu_op_e;

    localparam reg_addr_t REG_OPA    = 5'h00;
    localparam reg_addr_t REG_OPB    = 5'h04;
    localparam reg_addr_t REG_TARGET = 5'h08;
    localparam reg_addr_t REG_IMM    = 5'h0C;
    localparam reg_addr_t REG_CTRL   = 5'h10;
    localparam reg_addr_t REG_RESULT = 5'h14;
    localparam reg_addr_t REG_STATUS = 5'h18;
    localparam reg_addr_t REG_NADDR  = 5'h1C;

    localparam int IMM_HIGHLOW_BIT = 16;
    localparam int IMM_F1_BIT      = 17;
    localparam int IMM_F2_BIT      = 18;

    localparam int STAT_FLAG_BIT   = 0;
    localparam int STAT_ADDRCH_BIT = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        word_t      awaddr;
        logic       awvalid;
        word_t      wdata;
        logic       wvalid;
        logic       bready;
        word_t      araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
        logic       arready;
        word_t      rdata;
        logic [1:0] rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic    start;
        alu_op_e op;
        word_t   a;
        word_t   b;
        word_t   target;
        half_t   value;
        logic    highlow;
        logic    f1;
        logic    f2;
    } alu_req_t;

    typedef struct packed {
        word_t result;
        logic  flag;
        logic  addrch;
        word_t naddr;
    } alu_res_t;

endpackage

`default_nettype wire
